// File: all.f
ll_pkg.sv
desc_pkg.sv
sync_fifo.sv
ll_tx_parser.sv
ll_rx_builder.sv
comp_copy_unit.sv
tb_comp_copy_unit.sv

// File: Makefile
TOP = tb_comp_copy_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// File: tb_comp_copy_unit.sv
`default_nettype none

module tb_comp_copy_unit;

   timeunit 1ns;
   timeprecision 1ps;

   localparam time IN_DLY = 2ns;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic [31:0] tx_d_i = '0;
   logic [3:0]  tx_rem_i = '0;
   logic        tx_sof_n_i = 1'b1;
   logic        tx_eof_n_i = 1'b1;
   logic        tx_sop_n_i = 1'b1;
   logic        tx_eop_n_i = 1'b1;
   logic        tx_src_rdy_n_i = 1'b1;
   logic        tx_dst_rdy_n_o;
   logic [31:0] rx_d_o;
   logic [3:0]  rx_rem_o;
   logic        rx_sof_n_o;
   logic        rx_eof_n_o;
   logic        rx_sop_n_o;
   logic        rx_eop_n_o;
   logic        rx_src_rdy_n_o;
   logic        rx_dst_rdy_n_i = 1'b0;

   // Expected entry is {test id, sof_n, sop_n, eop_n, eof_n, rem, data}
   logic [43:0] exp_q [$];
   logic [43:0] exp_head = '0;
   logic        exp_avail = 1'b0;
   logic [39:0] rx_word;
   logic        rx_beat;
   logic [31:0] rng = 32'd32;
   logic [31:0] bp_rng = 32'd32;
   logic        bp_en = 1'b0;
   logic        gap_en = 1'b0;
   logic        frame_sent = 1'b0;
   int          errors = 0;
   int          beat_total = 0;
   int          cycles = 0;

   comp_copy_unit i_comp_copy_unit (.*);

   always #20 clk = ~clk;

   assign rx_word = {rx_sof_n_o, rx_sop_n_o, rx_eop_n_o, rx_eof_n_o, rx_rem_o, rx_d_o};
   assign rx_beat = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rand_next();
      rng = lcg_step(rng);
      return rng;
   endfunction

   function automatic int rand_range(input int n);
      rng = lcg_step(rng);
      return int'({8'h00, rng[31:8]}) % n;
   endfunction

   function automatic logic [3:0] rem_code(input int sel);
      case (sel)
         1:       return 4'b0001;
         2:       return 4'b0011;
         3:       return 4'b0111;
         default: return 4'b0000;
      endcase
   endfunction

   function automatic int valid_bytes(input logic [3:0] rem);
      case (rem)
         4'b0001: return 3;
         4'b0011: return 2;
         4'b0111: return 1;
         default: return 4;
      endcase
   endfunction

   function automatic string test_name(input logic [3:0] id);
      case (id)
         4'd1:    return "full_words";
         4'd2:    return "partial_rem";
         4'd3:    return "len_mismatch";
         4'd4:    return "random_backpressure";
         default: return "back_to_back";
      endcase
   endfunction

   // Entered and left a little after a rising edge
   task automatic drive_beat(input logic [31:0] d, input logic [3:0] r, input logic sof_n,
                             input logic eof_n, input logic sop_n, input logic eop_n);
      logic taken;
      int   idle;
      tx_d_i         = d;
      tx_rem_i       = r;
      tx_sof_n_i     = sof_n;
      tx_eof_n_i     = eof_n;
      tx_sop_n_i     = sop_n;
      tx_eop_n_i     = eop_n;
      tx_src_rdy_n_i = 1'b0;
      taken          = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = !tx_dst_rdy_n_o;
         @(posedge clk);
      end
      #(IN_DLY);
      tx_src_rdy_n_i = 1'b1;
      idle = gap_en ? rand_range(4) : 0;
      repeat (idle) begin
         @(posedge clk);
         #(IN_DLY);
      end
   endtask

   task automatic send_frame(input logic [3:0] id, input int nwords, input logic [3:0] rem_last,
                             input logic len_ok);
      logic [31:0] words [20];
      logic [31:0] hdr;
      logic [31:0] counted;
      logic [31:0] declared;
      logic [31:0] tmp;
      logic [2:0]  flags;
      logic [9:0]  task_idx;
      logic        last;
      int          nbytes;
      tmp      = rand_next();
      flags    = tmp[31:29];
      tmp      = rand_next();
      task_idx = tmp[31:22];
      nbytes   = valid_bytes(rem_last);
      counted  = 32'(4 * (nwords - 1) + nbytes);
      declared = len_ok ? counted : counted + 32'(1 + rand_range(9));
      frame_sent = 1'b1;
      beat_total += 2 * nwords + 12;
      // Whole expected frame goes in before the first beat
      for (int i = 0; i < nwords; i++) begin
         words[i] = rand_next();
         last = (i == nwords - 1);
         if (last) begin
            exp_q.push_back({id, (i != 0), (i != 0), 1'b0, 1'b1, rem_last,
                             words[i] & (32'hFFFF_FFFF << (8 * (4 - nbytes)))});
         end else begin
            exp_q.push_back({id, (i != 0), (i != 0), 1'b1, 1'b1, 4'b0000, words[i]});
         end
      end
      exp_q.push_back({id, 4'b1111, 4'b0000, flags, (declared != counted), 28'h0});
      exp_q.push_back({id, 4'b1111, 4'b0000, counted});
      exp_q.push_back({id, 4'b1111, 4'b0000, 22'h0, task_idx});
      exp_q.push_back({id, 4'b1110, 4'b0000, 32'(nwords)});
      for (int i = 0; i < 8; i++) begin
         hdr = rand_next();
         case (i)
            4:       hdr[31:29] = flags;
            5:       hdr = declared;
            6:       hdr[9:0] = task_idx;
            default: ;
         endcase
         tmp = rand_next();
         drive_beat(hdr, tmp[31:28], (i != 0), 1'b1, 1'b1, 1'b1);
      end
      for (int i = 0; i < nwords; i++) begin
         last = (i == nwords - 1);
         tmp  = rand_next();
         drive_beat(words[i], last ? rem_last : tmp[31:28], 1'b1, !last, (i != 0), !last);
      end
   endtask

   // Receive back-pressure holds off about three cycles in four
   always @(posedge clk) begin
      #(IN_DLY + 1ns);
      bp_rng = lcg_step(bp_rng);
      rx_dst_rdy_n_i = bp_en && (bp_rng[31:30] != 2'b11);
   end

   // Head of the reference queue as seen by the assertions
   always @(posedge clk) begin
      if (rst_n && rx_beat && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
      end
      exp_avail <= (exp_q.size() > 0);
      exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
   end

   a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
      !frame_sent |-> (rx_src_rdy_n_o && rx_sof_n_o && rx_eof_n_o && rx_sop_n_o && rx_eop_n_o
                       && !tx_dst_rdy_n_o))
      else begin
         errors++;
         $display("error idle_after_reset expected 111110 actual %b", $sampled({rx_src_rdy_n_o,
                  rx_sof_n_o, rx_eof_n_o, rx_sop_n_o, rx_eop_n_o, tx_dst_rdy_n_o}));
      end

   a_no_extra_beat: assert property (@(posedge clk) disable iff (!rst_n)
      rx_beat |-> exp_avail)
      else begin
         errors++;
         $display("receive beat %h arrived when no word was expected", $sampled(rx_word));
      end

   a_rx_word: assert property (@(posedge clk) disable iff (!rst_n)
      (rx_beat && exp_avail) |-> (rx_word == exp_head[39:0]))
      else begin
         errors++;
         $display("error %s expected %h actual %h", test_name($sampled(exp_head[43:40])),
                  $sampled(exp_head[39:0]), $sampled(rx_word));
      end

   always @(posedge clk) begin
      cycles++;
      if (cycles > beat_total * 4 + 1000) begin
         $display("timeout after %0d cycles with %0d words still expected", cycles, exp_q.size());
         $display("errors: %0d", errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      repeat (16) @(posedge clk);
      #(IN_DLY);
      rst_n = 1'b1;
      // Both sides stay quiet until the first frame
      repeat (20) @(posedge clk);
      #(IN_DLY);
      for (int f = 0; f < 3; f++) begin
         send_frame(4'd1, 1 + rand_range(20), 4'b0000, 1'b1);
      end
      send_frame(4'd2, 5, 4'b0001, 1'b1);
      send_frame(4'd2, 1, 4'b0011, 1'b1);
      send_frame(4'd2, 7, 4'b0111, 1'b1);
      for (int f = 0; f < 4; f++) begin
         send_frame(4'd3, 1 + rand_range(20), rem_code(rand_range(4)), 1'b0);
      end
      bp_en  = 1'b1;
      gap_en = 1'b1;
      for (int f = 0; f < 30; f++) begin
         send_frame(4'd4, 1 + rand_range(20), rem_code(rand_range(4)), rand_range(2) == 0);
      end
      bp_en  = 1'b0;
      gap_en = 1'b0;
      for (int f = 0; f < 8; f++) begin
         send_frame(4'd5, 1 + rand_range(20), rem_code(rand_range(4)), rand_range(2) == 0);
      end
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (10) @(posedge clk);
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: comp_copy_unit.sv
`default_nettype none

module comp_copy_unit (
   input  wire                        clk,
   input  wire                        rst_n,
   // Transmit LocalLink
   input  wire [ll_pkg::DATA_W-1:0]   tx_d_i,
   input  wire [ll_pkg::REM_W-1:0]    tx_rem_i,
   input  wire                        tx_sof_n_i,
   input  wire                        tx_eof_n_i,
   input  wire                        tx_sop_n_i,
   input  wire                        tx_eop_n_i,
   input  wire                        tx_src_rdy_n_i,
   output logic                       tx_dst_rdy_n_o,
   // Receive LocalLink
   output logic [ll_pkg::DATA_W-1:0]  rx_d_o,
   output logic [ll_pkg::REM_W-1:0]   rx_rem_o,
   output logic                       rx_sof_n_o,
   output logic                       rx_eof_n_o,
   output logic                       rx_sop_n_o,
   output logic                       rx_eop_n_o,
   output logic                       rx_src_rdy_n_o,
   input  wire                        rx_dst_rdy_n_i
);

   logic              pl_wr;
   ll_pkg::ll_word_t  pl_wdata;
   logic              pl_full;
   logic              pl_rd;
   ll_pkg::ll_word_t  pl_rdata;
   logic              pl_empty;
   logic              desc_wr;
   desc_pkg::desc_t   desc_wdata;
   logic              desc_full;
   logic              desc_rd;
   desc_pkg::desc_t   desc_rdata;
   logic              desc_empty;

   ll_tx_parser i_ll_tx_parser (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_d_i         (tx_d_i),
      .tx_rem_i       (tx_rem_i),
      .tx_sof_n_i     (tx_sof_n_i),
      .tx_eof_n_i     (tx_eof_n_i),
      .tx_sop_n_i     (tx_sop_n_i),
      .tx_eop_n_i     (tx_eop_n_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .pl_wr_o        (pl_wr),
      .pl_data_o      (pl_wdata),
      .pl_full_i      (pl_full),
      .desc_wr_o      (desc_wr),
      .desc_data_o    (desc_wdata),
      .desc_full_i    (desc_full)
   );

   // Payload words
   sync_fifo #(
      .T     (ll_pkg::ll_word_t),
      .DEPTH (desc_pkg::PAYLOAD_DEPTH)
   ) i_pl_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_i      (pl_wr),
      .wr_data_i (pl_wdata),
      .full_o    (pl_full),
      .rd_i      (pl_rd),
      .rd_data_o (pl_rdata),
      .empty_o   (pl_empty)
   );

   // One descriptor per frame in flight
   sync_fifo #(
      .T     (desc_pkg::desc_t),
      .DEPTH (desc_pkg::DESC_DEPTH)
   ) i_desc_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_i      (desc_wr),
      .wr_data_i (desc_wdata),
      .full_o    (desc_full),
      .rd_i      (desc_rd),
      .rd_data_o (desc_rdata),
      .empty_o   (desc_empty)
   );

   ll_rx_builder i_ll_rx_builder (
      .clk            (clk),
      .rst_n          (rst_n),
      .pl_rd_o        (pl_rd),
      .pl_data_i      (pl_rdata),
      .pl_empty_i     (pl_empty),
      .desc_rd_o      (desc_rd),
      .desc_data_i    (desc_rdata),
      .desc_empty_i   (desc_empty),
      .rx_d_o         (rx_d_o),
      .rx_rem_o       (rx_rem_o),
      .rx_sof_n_o     (rx_sof_n_o),
      .rx_eof_n_o     (rx_eof_n_o),
      .rx_sop_n_o     (rx_sop_n_o),
      .rx_eop_n_o     (rx_eop_n_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
   );

endmodule

`default_nettype wire

// File: ll_rx_builder.sv
`default_nettype none

module ll_rx_builder (
   input  wire                        clk,
   input  wire                        rst_n,
   output logic                       pl_rd_o,
   input  wire ll_pkg::ll_word_t      pl_data_i,
   input  wire                        pl_empty_i,
   output logic                       desc_rd_o,
   input  wire desc_pkg::desc_t       desc_data_i,
   input  wire                        desc_empty_i,
   output logic [ll_pkg::DATA_W-1:0]  rx_d_o,
   output logic [ll_pkg::REM_W-1:0]   rx_rem_o,
   output logic                       rx_sof_n_o,
   output logic                       rx_eof_n_o,
   output logic                       rx_sop_n_o,
   output logic                       rx_eop_n_o,
   output logic                       rx_src_rdy_n_o,
   input  wire                        rx_dst_rdy_n_i
);

   localparam int STAT_W = $clog2(desc_pkg::STATUS_WORDS);
   localparam logic [STAT_W-1:0] STAT_LAST = STAT_W'(desc_pkg::STATUS_WORDS - 1);

   typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_STAT} state_t;

   state_t                    state;
   logic [STAT_W-1:0]         stat_idx;
   desc_pkg::len_t            word_cnt;
   desc_pkg::len_t            byte_cnt;
   logic                      out_ack;
   logic                      load_ok;
   logic                      pl_take;
   logic                      stat_take;
   logic [ll_pkg::DATA_W-1:0] app_word;

   function automatic desc_pkg::len_t rem_bytes(input logic [ll_pkg::REM_W-1:0] rem);
      case (rem)
         ll_pkg::REM_3B: return desc_pkg::len_t'(3);
         ll_pkg::REM_2B: return desc_pkg::len_t'(2);
         ll_pkg::REM_1B: return desc_pkg::len_t'(1);
         default:        return desc_pkg::len_t'(ll_pkg::DATA_W / 8);
      endcase
   endfunction

   assign out_ack = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;
   // Output register is free or drains this cycle
   assign load_ok = rx_src_rdy_n_o || !rx_dst_rdy_n_i;

   // Payload streams ahead of its descriptor, status waits for it
   assign pl_take   = load_ok && !pl_empty_i && (state != ST_STAT);
   assign stat_take = load_ok && !desc_empty_i && (state == ST_STAT);

   assign pl_rd_o   = pl_take;
   assign desc_rd_o = stat_take && (stat_idx == STAT_LAST);

   always_comb begin
      app_word = '0;
      case (stat_idx)
         0: begin
            app_word[desc_pkg::APP_FLAGS_LSB +: $bits(desc_pkg::flags_t)] = desc_data_i.flags;
            app_word[desc_pkg::APP_MISMATCH_BIT] = (byte_cnt != desc_data_i.len);
         end
         1:       app_word = byte_cnt;
         2:       app_word = ll_pkg::DATA_W'(desc_data_i.task_idx);
         default: app_word = word_cnt;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state          <= ST_IDLE;
         stat_idx       <= '0;
         rx_src_rdy_n_o <= 1'b1;
         rx_sof_n_o     <= 1'b1;
         rx_eof_n_o     <= 1'b1;
         rx_sop_n_o     <= 1'b1;
         rx_eop_n_o     <= 1'b1;
      end else begin
         if (out_ack) begin
            rx_src_rdy_n_o <= 1'b1;
            rx_sof_n_o     <= 1'b1;
            rx_eof_n_o     <= 1'b1;
            rx_sop_n_o     <= 1'b1;
            rx_eop_n_o     <= 1'b1;
         end
         if (pl_take) begin
            rx_src_rdy_n_o <= 1'b0;
            rx_sof_n_o     <= (state != ST_IDLE);
            rx_sop_n_o     <= (state != ST_IDLE);
            rx_eop_n_o     <= !pl_data_i.last;
            rx_eof_n_o     <= 1'b1;
            stat_idx       <= '0;
            state          <= pl_data_i.last ? ST_STAT : ST_DATA;
         end else if (stat_take) begin
            rx_src_rdy_n_o <= 1'b0;
            rx_sof_n_o     <= 1'b1;
            rx_sop_n_o     <= 1'b1;
            rx_eop_n_o     <= 1'b1;
            rx_eof_n_o     <= (stat_idx != STAT_LAST);
            stat_idx       <= stat_idx + 1'b1;
            if (stat_idx == STAT_LAST) begin
               state <= ST_IDLE;
            end
         end
      end
   end

   // Output word and per-frame counters
   always_ff @(posedge clk) begin
      if (pl_take) begin
         rx_d_o   <= pl_data_i.data;
         rx_rem_o <= pl_data_i.rem;
         if (state == ST_IDLE) begin
            word_cnt <= desc_pkg::len_t'(1);
            byte_cnt <= rem_bytes(pl_data_i.rem);
         end else begin
            word_cnt <= word_cnt + 1'b1;
            byte_cnt <= byte_cnt + rem_bytes(pl_data_i.rem);
         end
      end else if (stat_take) begin
         rx_d_o   <= app_word;
         rx_rem_o <= ll_pkg::REM_FULL;
      end
   end

   a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_src_rdy_n_o && rx_dst_rdy_n_i) |=> $stable(rx_d_o));

endmodule

`default_nettype wire

// File: ll_tx_parser.sv
`default_nettype none

module ll_tx_parser (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire [ll_pkg::DATA_W-1:0]   tx_d_i,
   input  wire [ll_pkg::REM_W-1:0]    tx_rem_i,
   input  wire                        tx_sof_n_i,
   input  wire                        tx_eof_n_i,
   input  wire                        tx_sop_n_i,
   input  wire                        tx_eop_n_i,
   input  wire                        tx_src_rdy_n_i,
   output logic                       tx_dst_rdy_n_o,
   output logic                       pl_wr_o,
   output ll_pkg::ll_word_t           pl_data_o,
   input  wire                        pl_full_i,
   output logic                       desc_wr_o,
   output desc_pkg::desc_t            desc_data_o,
   input  wire                        desc_full_i
);

   localparam ll_pkg::hdr_cnt_t HDR_LAST  = ll_pkg::hdr_cnt_t'(ll_pkg::HDR_WORDS - 1);
   localparam ll_pkg::hdr_cnt_t POS_FLAGS = ll_pkg::hdr_cnt_t'(ll_pkg::HDR_FLAGS_IDX);
   localparam ll_pkg::hdr_cnt_t POS_LEN   = ll_pkg::hdr_cnt_t'(ll_pkg::HDR_LEN_IDX);
   localparam ll_pkg::hdr_cnt_t POS_TASK  = ll_pkg::hdr_cnt_t'(ll_pkg::HDR_TASK_IDX);

   logic                  in_payload;
   ll_pkg::hdr_cnt_t      hdr_cnt;
   desc_pkg::flags_t      flags_q;
   desc_pkg::len_t        len_q;
   desc_pkg::task_t       task_q;
   logic                  beat;
   logic                  start_mark;
   logic                  hdr_adv;
   logic                  pl_end;
   logic [ll_pkg::DATA_W-1:0] pl_d;
   logic [ll_pkg::REM_W-1:0]  pl_rem;

   assign beat = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;

   // Descriptor slot is reserved before the payload starts
   assign tx_dst_rdy_n_o = pl_full_i || (!in_payload && hdr_cnt == HDR_LAST && desc_full_i);

   // A frame opens on SOF or SOP, stray beats before it are dropped
   assign start_mark = !tx_sof_n_i || !tx_sop_n_i;
   assign hdr_adv    = beat && !in_payload && (hdr_cnt != '0 || start_mark);

   // Either end strobe closes the payload
   assign pl_end = !tx_eop_n_i || !tx_eof_n_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_payload <= 1'b0;
         hdr_cnt    <= '0;
      end else if (hdr_adv) begin
         hdr_cnt <= (hdr_cnt == HDR_LAST) ? '0 : hdr_cnt + 1'b1;
         if (hdr_cnt == HDR_LAST) begin
            in_payload <= 1'b1;
         end
      end else if (beat && in_payload && pl_end) begin
         in_payload <= 1'b0;
      end
   end

   // Header fields
   always_ff @(posedge clk) begin
      if (hdr_adv) begin
         if (hdr_cnt == POS_FLAGS) begin
            flags_q <= tx_d_i[ll_pkg::DATA_W-1 -: $bits(desc_pkg::flags_t)];
         end
         if (hdr_cnt == POS_LEN) begin
            len_q <= tx_d_i;
         end
         if (hdr_cnt == POS_TASK) begin
            task_q <= tx_d_i[$bits(desc_pkg::task_t)-1:0];
         end
      end
   end

   // Clear the bytes a partial last word does not carry
   always_comb begin
      pl_d   = tx_d_i;
      pl_rem = ll_pkg::REM_FULL;
      if (pl_end) begin
         case (tx_rem_i)
            ll_pkg::REM_3B: begin
               pl_d   = {tx_d_i[31:8], 8'h00};
               pl_rem = ll_pkg::REM_3B;
            end
            ll_pkg::REM_2B: begin
               pl_d   = {tx_d_i[31:16], 16'h0000};
               pl_rem = ll_pkg::REM_2B;
            end
            ll_pkg::REM_1B: begin
               pl_d   = {tx_d_i[31:24], 24'h000000};
               pl_rem = ll_pkg::REM_1B;
            end
            default: begin
               pl_d   = tx_d_i;
               pl_rem = ll_pkg::REM_FULL;
            end
         endcase
      end
   end

   assign pl_wr_o   = beat && in_payload;
   assign pl_data_o = '{data: pl_d, rem: pl_rem, last: pl_end};

   assign desc_wr_o   = beat && in_payload && pl_end;
   assign desc_data_o = '{flags: flags_q, len: len_q, task_idx: task_q};

   a_no_eop_in_header: assert property (@(posedge clk) disable iff (!rst_n)
      (beat && !in_payload) |-> tx_eop_n_i);

endmodule

`default_nettype wire

// File: sync_fifo.sv
`default_nettype none

module sync_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  wire   clk,
   input  wire   rst_n,
   input  wire   wr_i,
   input  wire T wr_data_i,
   output logic  full_o,
   input  wire   rd_i,
   output T      rd_data_o,
   output logic  empty_o
);

   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

   T mem [DEPTH];

   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [CNT_W-1:0] count;

   always_ff @(posedge clk) begin
      if (wr_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_i) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_i) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous read and write leaves the count alone
         case ({wr_i, rd_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rd_data_o = mem[rd_ptr];
   assign full_o    = (count == CNT_W'(DEPTH));
   assign empty_o   = (count == '0);

   a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
      wr_i |-> !full_o);

   a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
      rd_i |-> !empty_o);

endmodule

`default_nettype wire

// File: desc_pkg.sv
`default_nettype none

package desc_pkg;

   // Operation flags as in header word 4
   // Bit 2 compress, bit 1 decompress, bit 0 copy
   typedef logic [2:0] flags_t;

   typedef logic [9:0] task_t;

   typedef logic [31:0] len_t;

   // Per-frame record handed from parser to builder
   typedef struct packed {
      flags_t flags;
      len_t   len;
      task_t  task_idx;
   } desc_t;

   // Status words APP1 to APP4 after the payload
   localparam int STATUS_WORDS = 4;

   // APP1 layout
   localparam int APP_FLAGS_LSB    = 29;
   localparam int APP_MISMATCH_BIT = 28;

   // Buffering between parser and builder
   localparam int PAYLOAD_DEPTH = 16;
   localparam int DESC_DEPTH    = 4;

endpackage

`default_nettype wire

// File: ll_pkg.sv
`default_nettype none

package ll_pkg;

   // LocalLink data path
   localparam int DATA_W = 32;
   localparam int REM_W  = 4;

   // Remainder codes, valid bytes count from the top of the word
   localparam logic [REM_W-1:0] REM_FULL = 4'b0000;
   localparam logic [REM_W-1:0] REM_3B   = 4'b0001;
   localparam logic [REM_W-1:0] REM_2B   = 4'b0011;
   localparam logic [REM_W-1:0] REM_1B   = 4'b0111;

   // Descriptor header at the front of a transmit frame
   localparam int HDR_WORDS     = 8;
   localparam int HDR_FLAGS_IDX = 4;
   localparam int HDR_LEN_IDX   = 5;
   localparam int HDR_TASK_IDX  = 6;

   typedef logic [2:0] hdr_cnt_t;

   // One buffered payload beat
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [REM_W-1:0]  rem;
      logic              last;
   } ll_word_t;

endpackage

`default_nettype wire
